// ==== src.f ====
hw/pkt_chk_pkg.sv
hw/axis_pkt_lane.sv
hw/report_arbiter.sv
hw/pkt_stats.sv
hw/axis_array_pkt_chk.sv
bench/pkt_chk_asserts.sv
bench/tb_axis_array_pkt_chk.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --assert -Wno-fatal -f src.f --top-module tb_axis_array_pkt_chk -o sim_tb &&
./obj_dir/sim_tb | tee /dev/stderr | grep -q "ALL CHECKS PASSED" && exit 0 || exit 1

// ==== bench/tb_axis_array_pkt_chk.sv ====
// testbench for the checker array with xorshift packets on every port and a host on rpt_req
// plus a reference model that predicts each report and the final good and bad counts
module tb_axis_array_pkt_chk
    import pkt_chk_pkg::*;
();

    localparam int NPKT = 25;
    localparam int TOTAL = NPKT * NUM_PORTS;
    localparam int TIMEOUT_CYCLES = NPKT * NUM_PORTS * 40 + 1000;

    logic axis_in = 1'b0;
    logic rst = 1'b1;
    logic rpt_ack = 1'b0;
    axis_beat_t beat_in [NUM_PORTS];
    logic [NUM_PORTS-1:0] vld_in;
    logic [NUM_PORTS-1:0] tready;
    pkt_report_t report;
    logic rpt_req;
    logic [CNT_W-1:0] good_count;
    logic [CNT_W-1:0] bad_count;

    // stimulus tables filled at time 0 before the drivers start
    int pkt_len [NUM_PORTS][NPKT];
    logic [7:0] pkt_seed [NUM_PORTS][NPKT];
    int pkt_flip [NUM_PORTS][NPKT];
    logic pkt_bad [NUM_PORTS][NPKT];
    logic [31:0] pkt_gap [NUM_PORTS][NPKT];
    pkt_report_t exp_q [NUM_PORTS][$];
    // reports taken by the host per port
    int seen [NUM_PORTS] = '{default: 0};
    int cycles = 0;

    axis_array_pkt_chk uut (
        .axis_in    (axis_in),
        .rst        (rst),
        .beat       (beat_in),
        .tvalid     (vld_in),
        .tready     (tready),
        .report     (report),
        .rpt_req    (rpt_req),
        .rpt_ack    (rpt_ack),
        .good_count (good_count),
        .bad_count  (bad_count)
    );

    always #4 axis_in = ~axis_in;

    function automatic logic [31:0] next_rand(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic stop_run(input string what);
        $display("%s", what);
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_mismatch(input string name, input int got, input int exp);
        stop_run($sformatf("Error at time %0t: %s is %0d, expected %0d", $time, name, got, exp));
    endtask

    always @(posedge axis_in) begin
        cycles = cycles + 1;
        if (cycles > TIMEOUT_CYCLES) begin
            stop_run("timeout: not every packet was reported within the cycle limit");
        end
    end

    // one stream driver per port with beats changing on the falling edge
    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_drv
        axis_beat_t bt = '0;
        logic vld = 1'b0;

        assign beat_in[p] = bt;
        assign vld_in[p] = vld;

        initial begin
            int left;
            int idx;
            int n;
            int b;
            wait (!rst);
            @(negedge axis_in);
            for (int k = 0; k < NPKT; k++) begin
                left = pkt_len[p][k];
                idx = 0;
                b = 0;
                while (left > 0) begin
                    // a bad packet shortens its first beat to three bytes
                    n = (pkt_bad[p][k] && b == 0 && left > 4) ? 3 : ((left > 4) ? 4 : left);
                    if (pkt_gap[p][k][b % 32]) begin
                        vld = 1'b0;
                        @(negedge axis_in);
                    end
                    for (int j = 0; j < DATA_BYTES; j++) begin
                        bt.tdata[j] = 8'(int'(pkt_seed[p][k]) + idx + j);
                        bt.tkeep[j] = (j < n);
                        if (j < n && pkt_flip[p][k] > 0 && idx + j == pkt_flip[p][k]) begin
                            bt.tdata[j] = bt.tdata[j] ^ 8'h5a;
                        end
                    end
                    left = left - n;
                    idx = idx + n;
                    bt.tlast = (left == 0);
                    vld = 1'b1;
                    // tready only moves on the rising edge, so it is stable here
                    while (!tready[p]) begin
                        @(negedge axis_in);
                    end
                    @(negedge axis_in);
                    b = b + 1;
                end
                vld = 1'b0;
                while (seen[p] <= k) begin
                    assert (!tready[p])
                    else stop_run($sformatf("port %0d is ready while its report is pending", p));
                    @(negedge axis_in);
                end
            end
        end
    end

    initial begin
        logic [31:0] rs;
        int r;
        int len;
        int good_exp;
        int bad_exp;
        int proto_errs;
        pkt_report_t exp_r;
        pkt_report_t got;
        rs = 32'd40;
        good_exp = 0;
        bad_exp = 0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            for (int k = 0; k < NPKT; k++) begin
                rs = next_rand(rs);
                len = 1 + int'(rs % 80);
                rs = next_rand(rs);
                pkt_seed[p][k] = rs[7:0];
                rs = next_rand(rs);
                pkt_gap[p][k] = rs;
                rs = next_rand(rs);
                r = int'(rs % 20);
                pkt_len[p][k] = len;
                // flips never hit byte 0, so the seed stays intact
                pkt_flip[p][k] = (r == 0 && len > 1) ? 1 + int'(rs[31:8]) % (len - 1) : 0;
                pkt_bad[p][k] = (r == 1);
                exp_r.port = PORT_W'(p);
                exp_r.blen = BLEN_W'((len > 255) ? 255 : len);
                exp_r.seed = pkt_seed[p][k];
                exp_r.pattern_err = (pkt_flip[p][k] > 0);
                exp_r.keep_err = (r == 1 && len > 4);
                exp_r.mtu_err = (len > MTU_BYTES);
                if (exp_r.pattern_err || exp_r.keep_err || exp_r.mtu_err) begin
                    bad_exp = bad_exp + 1;
                end else begin
                    good_exp = good_exp + 1;
                end
                exp_q[p].push_back(exp_r);
            end
        end

        repeat (8) @(negedge axis_in);
        rst = 1'b0;

        // host side of the four-phase report handshake
        for (int i = 0; i < TOTAL; i++) begin
            while (!rpt_req) begin
                @(negedge axis_in);
            end
            got = report;
            assert (exp_q[got.port].size() > 0)
            else stop_run($sformatf("report from port %0d with no packet outstanding", got.port));
            exp_r = exp_q[got.port].pop_front();
            assert (got.blen == exp_r.blen)
            else report_mismatch("report.blen", int'(got.blen), int'(exp_r.blen));
            assert (got.seed == exp_r.seed)
            else report_mismatch("report.seed", int'(got.seed), int'(exp_r.seed));
            assert (got.pattern_err == exp_r.pattern_err)
            else report_mismatch("report.pattern_err", int'(got.pattern_err),
                                 int'(exp_r.pattern_err));
            assert (got.keep_err == exp_r.keep_err)
            else report_mismatch("report.keep_err", int'(got.keep_err), int'(exp_r.keep_err));
            assert (got.mtu_err == exp_r.mtu_err)
            else report_mismatch("report.mtu_err", int'(got.mtu_err), int'(exp_r.mtu_err));
            seen[got.port] = seen[got.port] + 1;
            rs = next_rand(rs);
            repeat (int'(rs % 4)) @(negedge axis_in);
            rpt_ack = 1'b1;
            @(negedge axis_in);
            while (rpt_req) begin
                @(negedge axis_in);
            end
            rs = next_rand(rs);
            repeat (int'(rs % 4)) @(negedge axis_in);
            rpt_ack = 1'b0;
            @(negedge axis_in);
        end

        repeat (20) @(negedge axis_in);
        assert (!rpt_req)
        else stop_run("a report arrived after every packet had been reported");
        // every lane has closed its last handshake and takes beats again
        for (int p = 0; p < NUM_PORTS; p++) begin
            assert (tready[p])
            else stop_run($sformatf("port %0d is not ready again after its last report", p));
        end
        assert (good_count == CNT_W'(good_exp))
        else report_mismatch("good_count", int'(good_count), good_exp);
        assert (bad_count == CNT_W'(bad_exp))
        else report_mismatch("bad_count", int'(bad_count), bad_exp);

        proto_errs = uut.u_arbiter.u_asserts.hold_errs + uut.u_arbiter.u_asserts.onehot_errs
                   + uut.u_arbiter.u_asserts.grant_errs;
        if (proto_errs == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            stop_run("a handshake assertion on the report arbiter failed");
        end
    end

endmodule

// ==== bench/pkt_chk_asserts.sv ====
// handshake and stability properties of the report arbiter
// bound into every report_arbiter instance and counts each kind of failure
module pkt_chk_asserts
    import pkt_chk_pkg::*;
(
    input logic                 axis_in,
    input logic                 rst,
    input logic [NUM_PORTS-1:0] lane_req,
    input logic [NUM_PORTS-1:0] lane_ack,
    input pkt_report_t          report,
    input logic                 rpt_req,
    input logic                 rpt_ack
);

    int hold_errs = 0;
    int onehot_errs = 0;
    int grant_errs = 0;

    // an offered report waits unchanged for the host
    assert property (@(posedge axis_in) disable iff (rst)
        (rpt_req && !rpt_ack) |=> (rpt_req && $stable(report)))
    else begin
        $error("rpt_req or report changed before rpt_ack");
        hold_errs++;
    end

    // one lane is served at a time and its ack drops before another lane gets one
    assert property (@(posedge axis_in) disable iff (rst)
        $onehot0(lane_ack)
        && (($past(lane_ack) == '0) || (lane_ack == '0) || (lane_ack == $past(lane_ack))))
    else begin
        $error("lane_ack high on more than one lane or moved between lanes");
        onehot_errs++;
    end

    // an ack only answers a lane that is asking
    assert property (@(posedge axis_in) disable iff (rst)
        ((lane_ack & ~$past(lane_ack) & ~lane_req) == '0))
    else begin
        $error("lane_ack rose without lane_req");
        grant_errs++;
    end

endmodule

bind report_arbiter pkt_chk_asserts u_asserts (.*);

// ==== hw/axis_array_pkt_chk.sv ====
// top of the checker array with one lane per port, a report arbiter and the counters
// the host drives the stream inputs and answers rpt_req with rpt_ack
module axis_array_pkt_chk
    import pkt_chk_pkg::*;
(
    input  logic                 axis_in,
    input  logic                 rst,
    input  axis_beat_t           beat [NUM_PORTS],
    input  logic [NUM_PORTS-1:0] tvalid,
    output logic [NUM_PORTS-1:0] tready,
    output pkt_report_t          report,
    output logic                 rpt_req,
    input  logic                 rpt_ack,
    output logic [CNT_W-1:0]     good_count,
    output logic [CNT_W-1:0]     bad_count
);

    pkt_report_t lane_report [NUM_PORTS];
    logic [NUM_PORTS-1:0] lane_req;
    logic [NUM_PORTS-1:0] lane_ack;

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_lane
        axis_pkt_lane u_lane (
            .axis_in  (axis_in),
            .rst      (rst),
            .port_id  (PORT_W'(p)),
            .beat     (beat[p]),
            .tvalid   (tvalid[p]),
            .tready   (tready[p]),
            .report   (lane_report[p]),
            .lane_req (lane_req[p]),
            .lane_ack (lane_ack[p])
        );
    end

    report_arbiter u_arbiter (
        .axis_in     (axis_in),
        .rst         (rst),
        .lane_report (lane_report),
        .lane_req    (lane_req),
        .lane_ack    (lane_ack),
        .report      (report),
        .rpt_req     (rpt_req),
        .rpt_ack     (rpt_ack)
    );

    // counts follow the arbiter output, so every packet is seen exactly once
    pkt_stats u_stats (
        .axis_in    (axis_in),
        .rst        (rst),
        .report     (report),
        .rpt_req    (rpt_req),
        .rpt_ack    (rpt_ack),
        .good_count (good_count),
        .bad_count  (bad_count)
    );

endmodule

// ==== hw/pkt_stats.sv ====
// good and bad packet counters fed from the serialized report channel
// one count per host handshake taken when the host first acknowledges
module pkt_stats
    import pkt_chk_pkg::*;
(
    input  logic             axis_in,
    input  logic             rst,
    input  pkt_report_t      report,
    input  logic             rpt_req,
    input  logic             rpt_ack,
    output logic [CNT_W-1:0] good_count,
    output logic [CNT_W-1:0] bad_count
);

    logic ack_q;
    logic first_hit;
    logic any_err;

    // rpt_ack stays high for several cycles so only its rising edge counts
    assign first_hit = rpt_req && rpt_ack && !ack_q;
    assign any_err = report.pattern_err || report.keep_err || report.mtu_err;

    always_ff @(posedge axis_in) begin
        if (rst) begin
            ack_q <= 1'b0;
            good_count <= '0;
            bad_count <= '0;
        end else begin
            ack_q <= rpt_ack;
            if (first_hit) begin
                if (any_err) begin
                    bad_count <= bad_count + 1'b1;
                end else begin
                    good_count <= good_count + 1'b1;
                end
            end
        end
    end

endmodule

// ==== hw/report_arbiter.sv ====
// round-robin serializer of lane reports onto the single report channel
// bridges each lane four-phase handshake to the host four-phase handshake
module report_arbiter
    import pkt_chk_pkg::*;
(
    input  logic                 axis_in,
    input  logic                 rst,
    input  pkt_report_t          lane_report [NUM_PORTS],
    input  logic [NUM_PORTS-1:0] lane_req,
    output logic [NUM_PORTS-1:0] lane_ack,
    output pkt_report_t          report,
    output logic                 rpt_req,
    input  logic                 rpt_ack
);

    typedef enum logic [1:0] {
        A_IDLE,
        A_OFFER,
        A_RELEASE,
        A_CLOSE
    } arb_state_t;

    arb_state_t state;
    logic [PORT_W-1:0] grant;
    // first lane looked at on the next grant
    logic [PORT_W-1:0] rr_ptr;
    logic any_req;
    logic [PORT_W-1:0] pick;

    // scan downward so the lane closest after rr_ptr wins
    always_comb begin
        int idx;
        any_req = 1'b0;
        pick = rr_ptr;
        for (int i = NUM_PORTS - 1; i >= 0; i--) begin
            idx = (int'(rr_ptr) + i) % NUM_PORTS;
            if (lane_req[idx]) begin
                any_req = 1'b1;
                pick = PORT_W'(idx);
            end
        end
    end

    assign rpt_req = (state == A_OFFER) || (state == A_RELEASE);

    always_comb begin
        lane_ack = '0;
        if ((state == A_RELEASE) || (state == A_CLOSE)) begin
            lane_ack[grant] = 1'b1;
        end
    end

    always_ff @(posedge axis_in) begin
        if (rst) begin
            state <= A_IDLE;
            grant <= '0;
            rr_ptr <= '0;
        end else begin
            case (state)
                A_IDLE: begin
                    if (any_req) begin
                        grant <= pick;
                        rr_ptr <= PORT_W'((int'(pick) + 1) % NUM_PORTS);
                        state <= A_OFFER;
                    end
                end
                A_OFFER: begin
                    if (rpt_ack) begin
                        state <= A_RELEASE;
                    end
                end
                A_RELEASE: begin
                    if (!lane_req[grant]) begin
                        state <= A_CLOSE;
                    end
                end
                A_CLOSE: begin
                    if (!rpt_ack) begin
                        state <= A_IDLE;
                    end
                end
                default: state <= A_IDLE;
            endcase
        end
    end

    // copy taken at grant time and held until the next grant
    always_ff @(posedge axis_in) begin
        if ((state == A_IDLE) && any_req) begin
            report <= lane_report[pick];
        end
    end

endmodule

// ==== hw/axis_pkt_lane.sv ====
// one receive port that counts bytes and checks the incrementing pattern, keep and MTU rules
// then hands a single report per packet to the arbiter over a four-phase handshake
module axis_pkt_lane
    import pkt_chk_pkg::*;
(
    input  logic              axis_in,
    input  logic              rst,
    input  logic [PORT_W-1:0] port_id,
    input  axis_beat_t        beat,
    input  logic              tvalid,
    output logic              tready,
    output pkt_report_t       report,
    output logic              lane_req,
    input  logic              lane_ack
);

    typedef enum logic [1:0] {
        S_RUN,
        S_REQ,
        S_DROP
    } lane_state_t;

    lane_state_t state;

    // next accepted beat opens a new packet
    logic first;
    logic [BLEN_W-1:0] blen_q;
    logic [7:0] seed_q;
    // expected value of the next kept byte wrapping mod 256
    logic [7:0] exp_q;
    logic pattern_err_q;
    logic keep_err_q;

    logic accept;
    logic [7:0] seed_now;
    logic [7:0] exp_now;
    logic [KEEP_CNT_W-1:0] keep_cnt;
    logic [DATA_BYTES-1:0] keep_inc;
    logic [BLEN_W:0] blen_sum;
    logic [BLEN_W-1:0] blen_next;
    logic beat_pattern_err;
    logic beat_keep_err;
    logic pattern_err_next;
    logic keep_err_next;
    logic mtu_err_next;

    assign accept = tvalid && tready;
    assign tready = (state == S_RUN);
    assign lane_req = (state == S_REQ);

    // byte 0 of the first beat is the seed
    assign seed_now = first ? beat.tdata[0] : seed_q;
    assign exp_now = first ? beat.tdata[0] : exp_q;

    always_comb begin
        keep_cnt = '0;
        beat_pattern_err = 1'b0;
        for (int i = 0; i < DATA_BYTES; i++) begin
            if (beat.tkeep[i]) begin
                keep_cnt = keep_cnt + 1'b1;
                if (beat.tdata[i] != exp_now + 8'(i)) begin
                    beat_pattern_err = 1'b1;
                end
            end
        end
    end

    // a contiguous keep from byte 0 plus one clears every set bit
    assign keep_inc = beat.tkeep + 1'b1;
    assign beat_keep_err = (beat.tkeep == '0)
                        || ((keep_inc & beat.tkeep) != '0)
                        || (!beat.tlast && !(&beat.tkeep));

    assign blen_sum = (BLEN_W + 1)'(blen_q) + (BLEN_W + 1)'(keep_cnt);
    assign blen_next = blen_sum[BLEN_W] ? '1 : blen_sum[BLEN_W-1:0];

    assign pattern_err_next = pattern_err_q || beat_pattern_err;
    assign keep_err_next = keep_err_q || beat_keep_err;
    // count only grows, so the final length decides the MTU flag
    assign mtu_err_next = int'(blen_next) > MTU_BYTES;

    always_ff @(posedge axis_in) begin
        if (rst) begin
            state <= S_RUN;
            first <= 1'b1;
            blen_q <= '0;
            pattern_err_q <= 1'b0;
            keep_err_q <= 1'b0;
        end else begin
            case (state)
                S_RUN: begin
                    if (accept) begin
                        if (beat.tlast) begin
                            state <= S_REQ;
                            first <= 1'b1;
                            blen_q <= '0;
                            pattern_err_q <= 1'b0;
                            keep_err_q <= 1'b0;
                        end else begin
                            first <= 1'b0;
                            blen_q <= blen_next;
                            pattern_err_q <= pattern_err_next;
                            keep_err_q <= keep_err_next;
                        end
                    end
                end
                S_REQ: begin
                    if (lane_ack) begin
                        state <= S_DROP;
                    end
                end
                S_DROP: begin
                    // hold off new beats until the arbiter has closed its side
                    if (!lane_ack) begin
                        state <= S_RUN;
                    end
                end
                default: state <= S_RUN;
            endcase
        end
    end

    always_ff @(posedge axis_in) begin
        if (accept) begin
            seed_q <= seed_now;
            exp_q <= exp_now + 8'(keep_cnt);
        end
        if (accept && beat.tlast) begin
            report <= '{
                port:        port_id,
                blen:        blen_next,
                seed:        seed_now,
                pattern_err: pattern_err_next,
                keep_err:    keep_err_next,
                mtu_err:     mtu_err_next
            };
        end
    end

endmodule

// ==== hw/pkt_chk_pkg.sv ====
// sizes and shared types for the AXI-stream packet checker array
// every RTL block pulls these in with a wildcard import in its header
package pkt_chk_pkg;

    // receive ports in the array
    localparam int NUM_PORTS = 4;

    // bytes carried by one beat
    localparam int DATA_BYTES = 4;

    // longest legal packet in bytes
    localparam int MTU_BYTES = 64;

    // byte count width that saturates at 255 so it can run past MTU_BYTES
    localparam int BLEN_W = 8;

    // port index width
    localparam int PORT_W = 2;

    // good and bad packet counter width
    localparam int CNT_W = 16;

    // kept-byte count of a single beat from 0 to DATA_BYTES
    localparam int KEEP_CNT_W = $clog2(DATA_BYTES + 1);

    // one stream beat with byte 0 in the low bits of tdata
    typedef struct packed {
        logic [DATA_BYTES-1:0][7:0] tdata;
        logic [DATA_BYTES-1:0]      tkeep;
        logic                       tlast;
    } axis_beat_t;

    // end-of-packet result from one lane
    typedef struct packed {
        logic [PORT_W-1:0] port;
        logic [BLEN_W-1:0] blen;
        logic [7:0]        seed;
        logic              pattern_err;
        logic              keep_err;
        logic              mtu_err;
    } pkt_report_t;

endpackage
